//--- vlog.f
+incdir+verilog
+incdir+verif
verilog/scaler_pkg.sv
verilog/serial_divide.sv
verilog/scaler_axil_regs.sv
verilog/scaler_cfggen.sv
verilog/scaler_cfg_shadow.sv
verilog/scaler_cfg_top.sv
verif/scaler_cfg_tb.sv

//--- Bender.yml
package:
  name: scaler_cfg

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/scaler_pkg.sv
      - verilog/serial_divide.sv
      - verilog/scaler_axil_regs.sv
      - verilog/scaler_cfggen.sv
      - verilog/scaler_cfg_shadow.sv
      - verilog/scaler_cfg_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - verif
    files:
      - verif/scaler_cfg_tb.sv

//--- verif/scaler_axil_bfm.svh
`ifndef SCALER_AXIL_BFM_SVH
`define SCALER_AXIL_BFM_SVH

task automatic axil_write(input reg_addr_e addr, input logic [31:0] data, input int hold);
  @(posedge SYS_CLK);
  awaddr_i  <= addr;
  wdata_i   <= data;
  awvalid_i <= 1'b1;
  wvalid_i  <= 1'b1;
  bready_i  <= 1'b0;
  @(negedge SYS_CLK);
  while (!(awready_o && wready_o)) @(negedge SYS_CLK);
  @(posedge SYS_CLK);  // address and data accepted on this edge
  awvalid_i <= 1'b0;
  wvalid_i  <= 1'b0;
  @(negedge SYS_CLK);
  while (!bvalid_o) @(negedge SYS_CLK);
  if (bresp_o !== 2'b00) begin
    err_hs++;
    $display("ERROR %0t: bresp is %b, expected OKAY", $time, bresp_o);
  end
  repeat (hold) begin
    @(negedge SYS_CLK);
    if (bvalid_o !== 1'b1) begin
      err_hs++;
      $display("ERROR %0t: bvalid dropped while bready was low", $time);
    end
  end
  @(posedge SYS_CLK);
  bready_i <= 1'b1;
  @(posedge SYS_CLK);  // the request register updates on this response handshake
  bready_i <= 1'b0;
endtask

task automatic axil_read(input reg_addr_e addr, output logic [31:0] data, input int hold);
  @(posedge SYS_CLK);
  araddr_i  <= addr;
  arvalid_i <= 1'b1;
  rready_i  <= 1'b0;
  @(negedge SYS_CLK);
  while (!arready_o) @(negedge SYS_CLK);
  @(posedge SYS_CLK);
  arvalid_i <= 1'b0;
  araddr_i  <= 8'hFC;  // park the address on an unmapped word
  @(negedge SYS_CLK);
  while (!rvalid_o) @(negedge SYS_CLK);
  data = rdata_o;
  if (rresp_o !== 2'b00) begin
    err_hs++;
    $display("ERROR %0t: rresp is %b, expected OKAY", $time, rresp_o);
  end
  repeat (hold) begin
    @(negedge SYS_CLK);
    if (rvalid_o !== 1'b1 || rdata_o !== data) begin
      err_hs++;
      $display("ERROR %0t: rvalid or rdata changed while rready was low", $time);
    end
  end
  @(posedge SYS_CLK);
  rready_i <= 1'b1;
  @(posedge SYS_CLK);
  rready_i <= 1'b0;
endtask

// busy is low for one cycle while an axis turns around to recompute
task automatic wait_idle(output logic [31:0] status);
  int idle_reads;
  idle_reads = 0;
  while (idle_reads < 2) begin
    axil_read(STATUS, status, 0);
    if (status[0])
      idle_reads = 0;
    else
      idle_reads++;
  end
endtask

function automatic scaler_vcfg_t expect_vcfg(input logic [1:0] mode, input int vout,
                                             input int vact);
  scaler_vcfg_t cfg;
  longint       n_lines;
  longint       factor;
  longint       resmax;
  longint       first;
  n_lines = (mode == 2'b01) ? `ACTIVE_LINES_PAL : `ACTIVE_LINES_NTSC;  // unboxed PAL only
  factor  = (longint'(1) << 17) / vout;
  resmax  = (factor * n_lines * vact + (longint'(1) << 23)) >> 24;
  if (mode == 2'b11)
    first = (resmax < 240) ? (288 - resmax) / 2 : 24;  // boxed PAL
  else
    first = (resmax < n_lines) ? (n_lines - resmax) / 2 : 0;
  cfg.vpos_1st_rdline  = 9'(first);
  cfg.vlines_in_needed = 9'((resmax < n_lines) ? resmax : n_lines);
  cfg.vlines_in_full   = 9'(n_lines);
  cfg.vlines_out       = `VOUT_W'(vout);
  cfg.v_interp_factor  = `DIVIDEND_W'(factor);
  return cfg;
endfunction

function automatic scaler_hcfg_t expect_hcfg(input int hout, input int hact);
  scaler_hcfg_t cfg;
  longint       factor;
  longint       resmax;
  factor = (longint'(1) << 17) / hout;
  resmax = (factor * 640 * hact + (longint'(1) << 22)) >> 23;
  cfg.hpos_1st_rdpixel  = 10'((resmax < 640) ? (640 - resmax) / 2 : 0);
  cfg.hpixels_in_needed = 10'((resmax < 640) ? resmax : 640);
  cfg.hpixels_in_full   = 10'd640;
  cfg.hpixels_out       = `HOUT_W'(hout);
  cfg.h_interp_factor   = `DIVIDEND_W'(factor);
  return cfg;
endfunction

// readback layout of the result registers
function automatic logic [31:0] cfg_word(input reg_addr_e addr, input scaler_vcfg_t v,
                                         input scaler_hcfg_t h);
  case (addr)
    VCFG0:   return 32'({v.vpos_1st_rdline, v.vlines_in_needed, v.vlines_in_full});
    VCFG1:   return 32'({v.vlines_out, v.v_interp_factor});
    HCFG0:   return 32'({h.hpos_1st_rdpixel, h.hpixels_in_needed, h.hpixels_in_full});
    HCFG1:   return 32'({h.hpixels_out, h.h_interp_factor});
    default: return 32'd0;
  endcase
endfunction

`endif

//--- verif/scaler_cfg_tb.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_cfg_tb
  import scaler_pkg::*;
();

  localparam int          NUM_ROWS       = 8;
  localparam int          BUS_HOLD       = 2;  // cycles bready/rready stay low
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * 200 + 500;
  localparam logic [31:0] SEED           = 32'h8b3c_a639;

  typedef struct packed {
    logic [1:0]         mode;   // bit 0 pal, bit 1 boxed
    logic [`VOUT_W-1:0] vout;
    logic [`HOUT_W-1:0] hout;
    logic [`VOUT_W-1:0] vact;
    logic [`HOUT_W-1:0] hact;
    logic               burst;  // decoy writes first so the real ones land while busy
  } row_t;

  logic         SYS_CLK;
  logic         rst_n_i;
  logic         vsync_i;
  logic [7:0]   awaddr_i;
  logic         awvalid_i;
  logic         awready_o;
  logic [31:0]  wdata_i;
  logic         wvalid_i;
  logic         wready_o;
  logic [1:0]   bresp_o;
  logic         bvalid_o;
  logic         bready_i;
  logic [7:0]   araddr_i;
  logic         arvalid_i;
  logic         arready_o;
  logic [31:0]  rdata_o;
  logic [1:0]   rresp_o;
  logic         rvalid_o;
  logic         rready_i;
  scaler_vcfg_t vcfg_o;
  scaler_hcfg_t hcfg_o;

  int   err_value = 0;
  int   err_hs    = 0;
  int   cycle_cnt = 0;
  row_t rows [NUM_ROWS];

  `include "scaler_axil_bfm.svh"

  scaler_cfg_top u_dut (.*);

  initial begin
    SYS_CLK = 1'b0;
    forever #10 SYS_CLK = ~SYS_CLK;
  end

  always @(posedge SYS_CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("value errors: %0d, handshake errors: %0d", err_value, err_hs);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_reg(input reg_addr_e addr, input logic [31:0] exp);
    logic [31:0] got;
    axil_read(addr, got, BUS_HOLD);
    if (got !== exp) begin
      err_value++;
      $display("ERROR %0t: register 0x%02h read 0x%08h, expected 0x%08h",
               $time, addr, got, exp);
    end
  endtask

  task automatic check_ports(input scaler_vcfg_t exp_v, input scaler_hcfg_t exp_h,
                             input string when_txt);
    if (vcfg_o !== exp_v || hcfg_o !== exp_h) begin
      err_value++;
      $display("ERROR %0t: %s, vcfg_o %h hcfg_o %h, expected %h %h",
               $time, when_txt, vcfg_o, hcfg_o, exp_v, exp_h);
    end
  endtask

  initial begin
    row_t         row;
    scaler_vcfg_t exp_v;
    scaler_hcfg_t exp_h;
    scaler_vcfg_t prev_v;
    scaler_hcfg_t prev_h;
    logic [31:0]  status;
    int unsigned  gap;
    rst_n_i   = 1'b0;
    vsync_i   = 1'b0;
    awaddr_i  = 8'd0;
    awvalid_i = 1'b0;
    wdata_i   = 32'd0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = 8'd0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    void'($urandom(SEED));
    rows[0] = '{2'd0, 11'd480,  12'd1280, 11'd480, 12'd1280, 1'b0};
    rows[1] = '{2'd1, 11'd576,  12'd720,  11'd576, 12'd704,  1'b0};
    rows[2] = '{2'd3, 11'd480,  12'd1024, 11'd480, 12'd1000, 1'b0};
    rows[3] = '{2'd0, 11'd1,    12'd2,    11'd240, 12'd200,  1'b0};  // upscale
    rows[4] = '{2'd3, 11'd1,    12'd4,    11'd240, 12'd100,  1'b0};  // boxed, resmax >= 240
    rows[5] = '{2'd1, 11'd2,    12'd1,    11'd288, 12'd320,  1'b0};
    rows[6] = '{2'd3, 11'd8,    12'd8,    11'd200, 12'd600,  1'b1};
    rows[7] = '{2'd0, 11'd720,  12'd1920, 11'd700, 12'd1900, 1'b0};
    prev_v = '0;
    prev_h = '0;

    repeat (10) @(posedge SYS_CLK);
    rst_n_i <= 1'b1;
    @(negedge SYS_CLK);
    if (awready_o || wready_o || bvalid_o || arready_o || rvalid_o) begin
      err_value++;
      $display("ERROR %0t: AXI ready or valid output high after reset", $time);
    end
    check_ports(prev_v, prev_h, "after reset");
    check_reg(CTRL, 32'd0);
    check_reg(VLINES_OUT, 32'd240);
    check_reg(HPIXELS_OUT, 32'd640);
    check_reg(VACTIVE, 32'd240);
    check_reg(HACTIVE, 32'd640);
    check_reg(STATUS, 32'd0);
    check_reg(VCFG0, 32'd0);
    check_reg(VCFG1, 32'd0);
    check_reg(HCFG0, 32'd0);
    check_reg(HCFG1, 32'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      row   = rows[i];
      exp_v = expect_vcfg(row.mode, row.vout, row.vact);
      exp_h = expect_hcfg(row.hout, row.hact);
      if (row.burst) begin
        axil_write(VLINES_OUT, 32'(row.vout) + 32'd3, BUS_HOLD);
        axil_write(HPIXELS_OUT, 32'(row.hout) + 32'd5, BUS_HOLD);
      end
      axil_write(CTRL, 32'(row.mode), BUS_HOLD);
      axil_write(VLINES_OUT, 32'(row.vout), BUS_HOLD);
      axil_write(HPIXELS_OUT, 32'(row.hout), BUS_HOLD);
      axil_write(VACTIVE, 32'(row.vact), BUS_HOLD);
      axil_write(HACTIVE, 32'(row.hact), BUS_HOLD);
      wait_idle(status);
      if (status[1] !== 1'b1) begin
        err_value++;
        $display("ERROR %0t: row %0d, pending not set once busy fell", $time, i);
      end
      gap = $urandom_range(1, 8);  // idle time before the frame boundary
      repeat (gap) begin
        @(negedge SYS_CLK);
        check_ports(prev_v, prev_h, "committed set changed before vsync");
      end
      @(posedge SYS_CLK);
      vsync_i <= 1'b1;
      @(negedge SYS_CLK);
      check_ports(prev_v, prev_h, "committed set changed before the vsync edge");
      @(posedge SYS_CLK);
      vsync_i <= 1'b0;
      @(negedge SYS_CLK);
      check_ports(exp_v, exp_h, "committed set after vsync");
      check_reg(VCFG0, cfg_word(VCFG0, exp_v, exp_h));
      check_reg(VCFG1, cfg_word(VCFG1, exp_v, exp_h));
      check_reg(HCFG0, cfg_word(HCFG0, exp_v, exp_h));
      check_reg(HCFG1, cfg_word(HCFG1, exp_v, exp_h));
      check_reg(STATUS, 32'd0);
      prev_v = exp_v;
      prev_h = exp_h;
    end

    $display("value errors: %0d, handshake errors: %0d", err_value, err_hs);
    if (err_value == 0 && err_hs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- verilog/scaler_cfg_top.sv
`timescale 1ns/1ps

module scaler_cfg_top
  import scaler_pkg::*;
(
  input  logic         SYS_CLK,
  input  logic         rst_n_i,
  input  logic         vsync_i,
  input  logic [7:0]   awaddr_i,
  input  logic         awvalid_i,
  output logic         awready_o,
  input  logic [31:0]  wdata_i,
  input  logic         wvalid_i,
  output logic         wready_o,
  output logic [1:0]   bresp_o,
  output logic         bvalid_o,
  input  logic         bready_i,
  input  logic [7:0]   araddr_i,
  input  logic         arvalid_i,
  output logic         arready_o,
  output logic [31:0]  rdata_o,
  output logic [1:0]   rresp_o,
  output logic         rvalid_o,
  input  logic         rready_i,
  output scaler_vcfg_t vcfg_o,
  output scaler_hcfg_t hcfg_o
);

  scaler_req_t  req;
  scaler_vcfg_t vcfg_gen;
  scaler_hcfg_t hcfg_gen;
  logic         vcfg_done;
  logic         hcfg_done;
  logic         busy;
  logic         pending;

  scaler_axil_regs u_regs (
    .SYS_CLK  (SYS_CLK),
    .rst_n_i  (rst_n_i),
    .awaddr_i (awaddr_i),
    .awvalid_i(awvalid_i),
    .awready_o(awready_o),
    .wdata_i  (wdata_i),
    .wvalid_i (wvalid_i),
    .wready_o (wready_o),
    .bresp_o  (bresp_o),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .araddr_i (araddr_i),
    .arvalid_i(arvalid_i),
    .arready_o(arready_o),
    .rdata_o  (rdata_o),
    .rresp_o  (rresp_o),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .req_o    (req),
    .busy_i   (busy),
    .pending_i(pending),
    .vcfg_i   (vcfg_o),   // host reads the committed set
    .hcfg_i   (hcfg_o)
  );

  scaler_cfggen u_cfggen (
    .SYS_CLK    (SYS_CLK),
    .rst_n_i    (rst_n_i),
    .req_i      (req),
    .vcfg_o     (vcfg_gen),
    .hcfg_o     (hcfg_gen),
    .vcfg_done_o(vcfg_done),
    .hcfg_done_o(hcfg_done),
    .busy_o     (busy)
  );

  scaler_cfg_shadow u_shadow (
    .SYS_CLK    (SYS_CLK),
    .rst_n_i    (rst_n_i),
    .vsync_i    (vsync_i),
    .vcfg_i     (vcfg_gen),
    .hcfg_i     (hcfg_gen),
    .vcfg_done_i(vcfg_done),
    .hcfg_done_i(hcfg_done),
    .vcfg_o     (vcfg_o),
    .hcfg_o     (hcfg_o),
    .pending_o  (pending)
  );

endmodule

//--- verilog/scaler_cfg_shadow.sv
`timescale 1ns/1ps

module scaler_cfg_shadow
  import scaler_pkg::*;
(
  input  logic         SYS_CLK,
  input  logic         rst_n_i,
  input  logic         vsync_i,
  input  scaler_vcfg_t vcfg_i,
  input  scaler_hcfg_t hcfg_i,
  input  logic         vcfg_done_i,
  input  logic         hcfg_done_i,
  output scaler_vcfg_t vcfg_o,
  output scaler_hcfg_t hcfg_o,
  output logic         pending_o
);

  scaler_vcfg_t vcfg_stage_q;
  scaler_hcfg_t hcfg_stage_q;

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vcfg_stage_q <= '0;
      hcfg_stage_q <= '0;
      vcfg_o       <= '0;
      hcfg_o       <= '0;
      pending_o    <= 1'b0;
    end else begin
      // both axes go out together so a frame never mixes old and new values
      if (vsync_i && pending_o) begin
        vcfg_o    <= vcfg_stage_q;
        hcfg_o    <= hcfg_stage_q;
        pending_o <= 1'b0;
      end
      if (vcfg_done_i) begin
        vcfg_stage_q <= vcfg_i;
        pending_o    <= 1'b1;  // a result landing with vsync waits for the next frame
      end
      if (hcfg_done_i) begin
        hcfg_stage_q <= hcfg_i;
        pending_o    <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/scaler_cfggen.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_cfggen
  import scaler_pkg::*;
(
  input  logic         SYS_CLK,
  input  logic         rst_n_i,
  input  scaler_req_t  req_i,
  output scaler_vcfg_t vcfg_o,
  output scaler_hcfg_t hcfg_o,
  output logic         vcfg_done_o,
  output logic         hcfg_done_o,
  output logic         busy_o
);

  localparam logic [`DIVIDEND_W-1:0] DIVIDEND = {1'b1, {(`DIVIDEND_W-1){1'b0}}};

  cfggen_phase_e          v_phase_q;
  logic [2:0]             v_wait_cnt_q;
  logic                   v_div_cmd_q;
  logic                   v_div_busy;
  logic                   v_div_done;
  logic [`DIVIDEND_W-1:0] v_factor;
  logic                   v_pal_q;
  logic                   v_boxed_q;
  logic [`VOUT_W-1:0]     v_out_q;
  logic [`VOUT_W-1:0]     v_active_q;
  logic                   v_req_diff;
  logic [8:0]             v_n64;
  logic [26:0]            v_inv_scale_q;
  logic [37:0]            v_res_full_q;
  logic [14:0]            v_resmax_q;
  logic [8:0]             v_needed_q;
  logic [8:0]             v_first_q;

  cfggen_phase_e          h_phase_q;
  logic [2:0]             h_wait_cnt_q;
  logic                   h_div_cmd_q;
  logic                   h_div_busy;
  logic                   h_div_done;
  logic [`DIVIDEND_W-1:0] h_factor;
  logic [`HOUT_W-1:0]     h_out_q;
  logic [`HOUT_W-1:0]     h_active_q;
  logic                   h_req_diff;
  logic [27:0]            h_inv_scale_q;
  logic [39:0]            h_res_full_q;
  logic [17:0]            h_resmax_q;
  logic [9:0]             h_needed_q;
  logic [9:0]             h_first_q;

  assign busy_o = (v_phase_q != RDY) || (h_phase_q != RDY);

  assign v_req_diff = {req_i.pal, req_i.pal_boxed, req_i.vlines_out, req_i.vactive} !=
                      {v_pal_q, v_boxed_q, v_out_q, v_active_q};
  assign h_req_diff = {req_i.hpixels_out, req_i.hactive} != {h_out_q, h_active_q};

  // 288 input lines only for unboxed PAL
  assign v_n64 = (v_pal_q && !v_boxed_q) ? `ACTIVE_LINES_PAL : `ACTIVE_LINES_NTSC;

  // multiply, round, clamp and centre, settles during WAIT
  always_ff @(posedge SYS_CLK) begin
    v_inv_scale_q <= v_factor * v_n64;
    v_res_full_q  <= v_inv_scale_q * v_active_q;
    v_resmax_q    <= {1'b0, v_res_full_q[37:24]} + {14'd0, v_res_full_q[23]};
    v_needed_q    <= (v_resmax_q < {6'd0, v_n64}) ? v_resmax_q[8:0] : v_n64;
    if (v_pal_q && v_boxed_q)
      v_first_q <= (v_resmax_q < {6'd0, `ACTIVE_LINES_NTSC}) ?
                   (`ACTIVE_LINES_PAL - v_resmax_q[8:0]) >> 1 : 9'd24;
    else
      v_first_q <= (v_resmax_q < {6'd0, v_n64}) ? (v_n64 - v_resmax_q[8:0]) >> 1 : 9'd0;

    h_inv_scale_q <= h_factor * `ACTIVE_PIXELS;
    h_res_full_q  <= h_inv_scale_q * h_active_q;
    h_resmax_q    <= {1'b0, h_res_full_q[39:23]} + {17'd0, h_res_full_q[22]};
    h_needed_q    <= (h_resmax_q < {8'd0, `ACTIVE_PIXELS}) ? h_resmax_q[9:0] : `ACTIVE_PIXELS;
    h_first_q     <= (h_resmax_q < {8'd0, `ACTIVE_PIXELS}) ?
                     (`ACTIVE_PIXELS - h_resmax_q[9:0]) >> 1 : 10'd0;
  end

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_phase_q    <= RDY;
      v_wait_cnt_q <= 3'd0;
      v_div_cmd_q  <= 1'b0;
      v_pal_q      <= 1'b0;  // matches the register defaults
      v_boxed_q    <= 1'b0;
      v_out_q      <= `VOUT_W'(`ACTIVE_LINES_NTSC);
      v_active_q   <= `VOUT_W'(`ACTIVE_LINES_NTSC);
      vcfg_o       <= '0;
      vcfg_done_o  <= 1'b0;
    end else begin
      v_div_cmd_q <= 1'b0;
      vcfg_done_o <= 1'b0;
      case (v_phase_q)
        RDY: begin
          if (v_req_diff && !v_div_busy) begin
            v_phase_q   <= DIVWAIT;
            v_div_cmd_q <= 1'b1;
            v_pal_q     <= req_i.pal;
            v_boxed_q   <= req_i.pal_boxed;
            v_out_q     <= req_i.vlines_out;
            v_active_q  <= req_i.vactive;
          end
        end
        DIVWAIT: begin
          if (v_div_done) begin
            v_phase_q    <= WAIT;
            v_wait_cnt_q <= 3'd4;
          end
        end
        WAIT: begin
          if (v_wait_cnt_q == 3'd0)
            v_phase_q <= OUT;
          else
            v_wait_cnt_q <= v_wait_cnt_q - 3'd1;
        end
        OUT: begin
          v_phase_q   <= RDY;
          vcfg_done_o <= 1'b1;
          vcfg_o      <= '{vpos_1st_rdline:  v_first_q,
                           vlines_in_needed: v_needed_q,
                           vlines_in_full:   v_n64,      // 288 only for unboxed PAL
                           vlines_out:       v_out_q,
                           v_interp_factor:  v_factor};
        end
        default: v_phase_q <= RDY;
      endcase
    end
  end

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      h_phase_q    <= RDY;
      h_wait_cnt_q <= 3'd0;
      h_div_cmd_q  <= 1'b0;
      h_out_q      <= `HOUT_W'(`ACTIVE_PIXELS);
      h_active_q   <= `HOUT_W'(`ACTIVE_PIXELS);
      hcfg_o       <= '0;
      hcfg_done_o  <= 1'b0;
    end else begin
      h_div_cmd_q <= 1'b0;
      hcfg_done_o <= 1'b0;
      case (h_phase_q)
        RDY: begin
          if (h_req_diff && !h_div_busy) begin
            h_phase_q   <= DIVWAIT;
            h_div_cmd_q <= 1'b1;
            h_out_q     <= req_i.hpixels_out;
            h_active_q  <= req_i.hactive;
          end
        end
        DIVWAIT: begin
          if (h_div_done) begin
            h_phase_q    <= WAIT;
            h_wait_cnt_q <= 3'd4;
          end
        end
        WAIT: begin
          if (h_wait_cnt_q == 3'd0)
            h_phase_q <= OUT;
          else
            h_wait_cnt_q <= h_wait_cnt_q - 3'd1;
        end
        OUT: begin
          h_phase_q   <= RDY;
          hcfg_done_o <= 1'b1;
          hcfg_o      <= '{hpos_1st_rdpixel:  h_first_q,
                           hpixels_in_needed: h_needed_q,
                           hpixels_in_full:   `ACTIVE_PIXELS,
                           hpixels_out:       h_out_q,
                           h_interp_factor:   h_factor};
        end
        default: h_phase_q <= RDY;
      endcase
    end
  end

  serial_divide #(
    .DIVIDEND_W(`DIVIDEND_W),
    .DIVISOR_W (`VOUT_W)
  ) u_vdiv (
    .SYS_CLK     (SYS_CLK),
    .rst_n_i     (rst_n_i),
    .divide_cmd_i(v_div_cmd_q),
    .dividend_i  (DIVIDEND),
    .divisor_i   (v_out_q),
    .quotient_o  (v_factor),
    .busy_o      (v_div_busy),
    .done_o      (v_div_done)
  );

  serial_divide #(
    .DIVIDEND_W(`DIVIDEND_W),
    .DIVISOR_W (`HOUT_W)
  ) u_hdiv (
    .SYS_CLK     (SYS_CLK),
    .rst_n_i     (rst_n_i),
    .divide_cmd_i(h_div_cmd_q),
    .dividend_i  (DIVIDEND),
    .divisor_i   (h_out_q),
    .quotient_o  (h_factor),
    .busy_o      (h_div_busy),
    .done_o      (h_div_done)
  );

endmodule

//--- verilog/scaler_axil_regs.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_axil_regs
  import scaler_pkg::*;
(
  input  logic         SYS_CLK,
  input  logic         rst_n_i,
  input  logic [7:0]   awaddr_i,
  input  logic         awvalid_i,
  output logic         awready_o,
  input  logic [31:0]  wdata_i,
  input  logic         wvalid_i,
  output logic         wready_o,
  output logic [1:0]   bresp_o,
  output logic         bvalid_o,
  input  logic         bready_i,
  input  logic [7:0]   araddr_i,
  input  logic         arvalid_i,
  output logic         arready_o,
  output logic [31:0]  rdata_o,
  output logic [1:0]   rresp_o,
  output logic         rvalid_o,
  input  logic         rready_i,
  output scaler_req_t  req_o,
  input  logic         busy_i,
  input  logic         pending_i,
  input  scaler_vcfg_t vcfg_i,
  input  scaler_hcfg_t hcfg_i
);

  logic [7:0]  wr_addr_q;
  logic [31:0] wr_data_q;
  logic [31:0] rd_mux;

  assign bresp_o = 2'b00;  // OKAY
  assign rresp_o = 2'b00;  // OKAY

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      // address and data are taken in the same cycle
      awready_o <= awvalid_i && wvalid_i && !awready_o && !bvalid_o;
      wready_o  <= awvalid_i && wvalid_i && !awready_o && !bvalid_o;
      if (awvalid_i && awready_o)
        bvalid_o <= 1'b1;
      else if (bready_i)
        bvalid_o <= 1'b0;

      arready_o <= arvalid_i && !arready_o && !rvalid_o;
      if (arvalid_i && arready_o)
        rvalid_o <= 1'b1;
      else if (rready_i)
        rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge SYS_CLK) begin
    if (awvalid_i && awready_o) begin
      wr_addr_q <= awaddr_i;
      wr_data_q <= wdata_i;
    end
    if (arvalid_i && arready_o)
      rdata_o <= rd_mux;  // held until rready
  end

  // request registers are updated on the response handshake
  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_o.pal         <= 1'b0;
      req_o.pal_boxed   <= 1'b0;
      req_o.vlines_out  <= `VOUT_W'(`ACTIVE_LINES_NTSC);
      req_o.hpixels_out <= `HOUT_W'(`ACTIVE_PIXELS);
      req_o.vactive     <= `VOUT_W'(`ACTIVE_LINES_NTSC);
      req_o.hactive     <= `HOUT_W'(`ACTIVE_PIXELS);
    end else if (bvalid_o && bready_i) begin
      case (reg_addr_e'(wr_addr_q))
        CTRL: begin
          req_o.pal       <= wr_data_q[0];
          req_o.pal_boxed <= wr_data_q[1];
        end
        VLINES_OUT:  req_o.vlines_out  <= wr_data_q[`VOUT_W-1:0];
        HPIXELS_OUT: req_o.hpixels_out <= wr_data_q[`HOUT_W-1:0];
        VACTIVE:     req_o.vactive     <= wr_data_q[`VOUT_W-1:0];
        HACTIVE:     req_o.hactive     <= wr_data_q[`HOUT_W-1:0];
        default: ;  // status and results are read only
      endcase
    end
  end

  always_comb begin
    case (reg_addr_e'(araddr_i))
      CTRL:        rd_mux = {30'd0, req_o.pal_boxed, req_o.pal};
      VLINES_OUT:  rd_mux = 32'(req_o.vlines_out);
      HPIXELS_OUT: rd_mux = 32'(req_o.hpixels_out);
      VACTIVE:     rd_mux = 32'(req_o.vactive);
      HACTIVE:     rd_mux = 32'(req_o.hactive);
      STATUS:      rd_mux = {30'd0, pending_i, busy_i};
      VCFG0:       rd_mux = 32'({vcfg_i.vpos_1st_rdline, vcfg_i.vlines_in_needed,
                                 vcfg_i.vlines_in_full});
      VCFG1:       rd_mux = 32'({vcfg_i.vlines_out, vcfg_i.v_interp_factor});
      HCFG0:       rd_mux = 32'({hcfg_i.hpos_1st_rdpixel, hcfg_i.hpixels_in_needed,
                                 hcfg_i.hpixels_in_full});
      HCFG1:       rd_mux = 32'({hcfg_i.hpixels_out, hcfg_i.h_interp_factor});
      default:     rd_mux = 32'd0;
    endcase
  end

endmodule

//--- verilog/serial_divide.sv
`timescale 1ns/1ps

module serial_divide #(
  parameter int DIVIDEND_W = 18,
  parameter int DIVISOR_W  = 11
) (
  input  logic                  SYS_CLK,
  input  logic                  rst_n_i,
  input  logic                  divide_cmd_i,
  input  logic [DIVIDEND_W-1:0] dividend_i,
  input  logic [DIVISOR_W-1:0]  divisor_i,
  output logic [DIVIDEND_W-1:0] quotient_o,
  output logic                  busy_o,
  output logic                  done_o
);

  localparam int CNT_W = $clog2(DIVIDEND_W + 1);

  logic [DIVISOR_W-1:0] divisor_q;
  logic [DIVISOR_W-1:0] rem_q;
  logic [CNT_W-1:0]     cnt_q;
  logic [DIVISOR_W:0]   rem_shift;
  logic [DIVISOR_W:0]   rem_diff;
  logic                 take;

  // quotient register doubles as the dividend shift register
  assign rem_shift = {rem_q, quotient_o[DIVIDEND_W-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};
  assign take      = (rem_shift >= {1'b0, divisor_q});

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;
      if (divide_cmd_i && !busy_o) begin
        busy_o <= 1'b1;
        cnt_q  <= CNT_W'(DIVIDEND_W);
      end else if (busy_o) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin  // last quotient bit goes in now
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge SYS_CLK) begin
    if (divide_cmd_i && !busy_o) begin
      quotient_o <= dividend_i;
      divisor_q  <= divisor_i;
      rem_q      <= '0;
    end else if (busy_o) begin
      quotient_o <= {quotient_o[DIVIDEND_W-2:0], take};
      rem_q      <= take ? rem_diff[DIVISOR_W-1:0] : rem_shift[DIVISOR_W-1:0];
    end
  end

endmodule

//--- verilog/scaler_pkg.sv
`include "scaler_defs.svh"

package scaler_pkg;

  typedef struct packed {
    logic               pal;          // 0 = NTSC, 1 = PAL
    logic               pal_boxed;    // PAL shown in a 240 line box
    logic [`VOUT_W-1:0] vlines_out;
    logic [`HOUT_W-1:0] hpixels_out;
    logic [`VOUT_W-1:0] vactive;      // active output lines
    logic [`HOUT_W-1:0] hactive;      // active output pixels
  } scaler_req_t;

  typedef struct packed {
    logic [8:0]             vpos_1st_rdline;
    logic [8:0]             vlines_in_needed;
    logic [8:0]             vlines_in_full;
    logic [`VOUT_W-1:0]     vlines_out;
    logic [`DIVIDEND_W-1:0] v_interp_factor;
  } scaler_vcfg_t;

  typedef struct packed {
    logic [9:0]             hpos_1st_rdpixel;
    logic [9:0]             hpixels_in_needed;
    logic [9:0]             hpixels_in_full;
    logic [`HOUT_W-1:0]     hpixels_out;
    logic [`DIVIDEND_W-1:0] h_interp_factor;
  } scaler_hcfg_t;

  typedef enum logic [1:0] {
    RDY,
    DIVWAIT,
    WAIT,
    OUT
  } cfggen_phase_e;

  typedef enum logic [7:0] {
    CTRL        = 8'h00,
    VLINES_OUT  = 8'h04,
    HPIXELS_OUT = 8'h08,
    VACTIVE     = 8'h0C,
    HACTIVE     = 8'h10,
    STATUS      = 8'h14,
    VCFG0       = 8'h18,
    VCFG1       = 8'h1C,
    HCFG0       = 8'h20,
    HCFG1       = 8'h24
  } reg_addr_e;

endpackage

//--- verilog/scaler_defs.svh
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

// input frame geometry as delivered by the console
`define ACTIVE_LINES_NTSC 9'd240
`define ACTIVE_LINES_PAL  9'd288
`define ACTIVE_PIXELS     10'd640

// dividend of the factor division, value is 2^(DIVIDEND_W-1)
`define DIVIDEND_W 18

// output line and pixel count widths
`define VOUT_W 11
`define HOUT_W 12

`endif
